// File: Makefile
TOP = tb_zynq_bridge
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	verilator --lint-only -Wall --top-module zynq_bridge_top hdl/zynq_bridge_pkg.sv \
		hdl/host_addr_translator.sv hdl/io_request_router.sv hdl/dram_addr_translator.sv \
		hdl/mem_profiler.sv hdl/shell_csr_file.sv hdl/zynq_bridge_top.sv

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/dram_addr_translator.sv
`timescale 1ns/100ps
`default_nettype none

module dram_addr_translator
   import zynq_bridge_pkg::*;
(
   input  wire                     aclk_i,
   input  wire                     reset_i,
   input  wire bp_req_s            dram_req_i,
   input  wire [addr_width_lp-1:0] dram_base_i,
   output bp_req_s                 ps_dram_o,
   output logic                    dram_oob_o
);

   logic [addr_width_lp-1:0] dram_offset;
   logic                     over_limit;

   // XOR strips the BlackParrot DRAM base without a subtractor
   assign dram_offset = dram_req_i.addr ^ dram_base_lp;

   // an address without the region bit also lands here since its offset wraps high
   assign over_limit = dram_offset >= dram_limit_lp;

   always_ff @(posedge aclk_i) begin
      if (reset_i) begin
         ps_dram_o.valid <= 1'b0;
         dram_oob_o      <= 1'b0;
      end else begin
         ps_dram_o.valid <= dram_req_i.valid;
         dram_oob_o      <= dram_req_i.valid & over_limit;
      end
      ps_dram_o.write <= dram_req_i.write;
      // base of the buffer that Linux on the PS allocated for the core
      ps_dram_o.addr  <= dram_offset + dram_base_i;
   end

   // the core should only send cached DRAM traffic on this path
   a_dram_region: assert property (@(posedge aclk_i) disable iff (reset_i)
      dram_req_i.valid |-> dram_req_i.addr.dram_view.region)
      else $error("dram request %h outside DRAM region", dram_req_i.addr);

endmodule

`default_nettype wire

// File: hdl/host_addr_translator.sv
`timescale 1ns/100ps
`default_nettype none

module host_addr_translator
   import zynq_bridge_pkg::*;
(
   input  wire            aclk_i,
   input  wire            reset_i,
   input  wire host_req_s host_req_i,
   output bp_req_s        bp_req_o
);

   logic [addr_width_lp-1:0] host_addr;
   logic [addr_width_lp-1:0] bp_addr;

   assign host_addr = addr_width_lp'(host_req_i.addr);

   // the GP1 port has already stripped 0x8000_0000, so the DRAM half gets it back
   // and the upper half lands at the bottom of BlackParrot local space
   assign bp_addr = (host_addr < host_split_lp) ? (host_addr + dram_base_lp)
                                                : (host_addr - host_split_lp);

   always_ff @(posedge aclk_i) begin
      if (reset_i) begin
         bp_req_o.valid <= 1'b0;
      end else begin
         bp_req_o.valid <= host_req_i.valid;
      end
      bp_req_o.write <= host_req_i.write;
      bp_req_o.addr  <= bp_addr;
   end

   // only 256 MB of local space is mapped, covering tiles 0 to 15
   a_window_range: assert property (@(posedge aclk_i) disable iff (reset_i)
      host_req_i.valid |-> (host_addr < (host_split_lp + dram_limit_lp)))
      else $error("host window address %h beyond mapped range", host_addr);

endmodule

`default_nettype wire

// File: hdl/io_request_router.sv
`timescale 1ns/100ps
`default_nettype none

module io_request_router
   import zynq_bridge_pkg::*;
(
   input  wire          aclk_i,
   input  wire          reset_i,
   input  wire bp_req_s io_req_i,
   output bp_req_s      host_io_o,
   output bp_req_s      periph_io_o
);

   // device number where the host region ends
   localparam bp_addr_u split_addr_lp = io_split_lp;

   logic to_host;

   assign to_host = io_req_i.addr.local_view.device < split_addr_lp.local_view.device;

   always_ff @(posedge aclk_i) begin
      if (reset_i) begin
         host_io_o.valid   <= 1'b0;
         periph_io_o.valid <= 1'b0;
      end else begin
         host_io_o.valid   <= io_req_i.valid & to_host;
         periph_io_o.valid <= io_req_i.valid & ~to_host;
      end
      // both channels carry the same payload, only valid tells them apart
      host_io_o.write   <= io_req_i.write;
      host_io_o.addr    <= io_req_i.addr;
      periph_io_o.write <= io_req_i.write;
      periph_io_o.addr  <= io_req_i.addr;
   end

   a_one_channel: assert property (@(posedge aclk_i) disable iff (reset_i)
      !(host_io_o.valid && periph_io_o.valid))
      else $error("io request sent to both channels");

endmodule

`default_nettype wire

// File: hdl/mem_profiler.sv
`timescale 1ns/100ps
`default_nettype none

module mem_profiler
   import zynq_bridge_pkg::*;
(
   input  wire                                aclk_i,
   input  wire                                bp_reset_i,
   input  wire bp_req_s                       dram_req_i,
   output logic [3:0][data_width_lp-1:0]      profile_o
);

   localparam int region_bits_lp = $clog2(profile_bits_lp);

   logic [region_bits_lp-1:0]  region_idx;
   logic [profile_bits_lp-1:0] profile_r;

   // each bit stands for one 8 MB slice of the 1 GB above the DRAM base
   assign region_idx = dram_req_i.addr.dram_view.offset[profile_lsb_lp +: region_bits_lp];

   // sticky until the core goes back into reset, so a run leaves its footprint
   // behind for the PS to read after the program finishes
   always_ff @(posedge aclk_i) begin
      if (bp_reset_i) begin
         profile_r <= '0;
      end else if (dram_req_i.valid) begin
         profile_r[region_idx] <= 1'b1;
      end
   end

   // word 0 holds regions 0 to 31
   assign profile_o = profile_r;

endmodule

`default_nettype wire

// File: hdl/shell_csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module shell_csr_file
   import zynq_bridge_pkg::*;
(
   input  wire                            aclk_i,
   input  wire                            reset_i,
   input  wire csr_cmd_s                  csr_cmd_i,
   input  wire [3:0][data_width_lp-1:0]   profile_i,
   output logic [data_width_lp-1:0]       csr_rdata_o,
   output logic                           csr_rvalid_o,
   output logic                           ctrl_reset_n_o,
   output logic [addr_width_lp-1:0]       dram_base_o
);

   logic [data_width_lp-1:0] ctrl_r;
   logic [data_width_lp-1:0] dram_alloc_r;
   logic [data_width_lp-1:0] dram_base_r;
   logic [data_width_lp-1:0] rdata_mux;

   // only registers 0 to 2 are writable, the rest are status
   always_ff @(posedge aclk_i) begin
      if (reset_i) begin
         ctrl_r       <= '0;
         dram_alloc_r <= '0;
         dram_base_r  <= '0;
      end else if (csr_cmd_i.wr) begin
         case (csr_cmd_i.idx)
            3'd0: ctrl_r <= csr_cmd_i.data;
            3'd1: dram_alloc_r <= csr_cmd_i.data;
            3'd2: dram_base_r <= csr_cmd_i.data;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (csr_cmd_i.idx)
         3'd0: rdata_mux = ctrl_r;
         3'd1: rdata_mux = dram_alloc_r;
         3'd2: rdata_mux = dram_base_r;
         3'd3: rdata_mux = '0;
         // indices 4 to 7 map onto the profile words, low word first
         default: rdata_mux = profile_i[csr_cmd_i.idx[1:0]];
      endcase
   end

   always_ff @(posedge aclk_i) begin
      if (reset_i) begin
         csr_rvalid_o <= 1'b0;
      end else begin
         csr_rvalid_o <= csr_cmd_i.rd;
      end
      csr_rdata_o <= rdata_mux;
   end

   // bit 0 of register 0 lets the core run
   assign ctrl_reset_n_o = ctrl_r[0];
   assign dram_base_o    = dram_base_r;

   a_single_access: assert property (@(posedge aclk_i) disable iff (reset_i)
      !(csr_cmd_i.wr && csr_cmd_i.rd))
      else $error("csr read and write strobes high together");

endmodule

`default_nettype wire

// File: hdl/zynq_bridge_pkg.sv
`default_nettype none

package zynq_bridge_pkg;

   localparam int addr_width_lp      = 32;
   localparam int host_addr_width_lp = 30;
   localparam int data_width_lp      = 32;
   localparam int profile_bits_lp    = 128;
   localparam int profile_lsb_lp     = 23;
   localparam int csr_idx_width_lp   = 3;

   // BlackParrot cached DRAM starts here
   localparam logic [addr_width_lp-1:0] dram_base_lp  = 32'h8000_0000;
   // GP1 window below this maps to DRAM, above it to local space
   localparam logic [addr_width_lp-1:0] host_split_lp = 32'h2000_0000;
   // devices below this address belong to the host
   localparam logic [addr_width_lp-1:0] io_split_lp   = 32'h0020_0000;
   // PS only hands out 256 MB to the core
   localparam logic [addr_width_lp-1:0] dram_limit_lp = 32'h1000_0000;

   typedef struct packed {
      logic        region;
      logic [30:0] offset;
   } bp_dram_addr_s;

   // local space is a zero top bit, tile, device and a 1 MB offset
   typedef struct packed {
      logic        zero;
      logic [6:0]  tile;
      logic [3:0]  device;
      logic [19:0] offset;
   } bp_local_addr_s;

   typedef union packed {
      bp_dram_addr_s  dram_view;
      bp_local_addr_s local_view;
   } bp_addr_u;

   typedef struct packed {
      logic                          valid;
      logic                          write;
      logic [host_addr_width_lp-1:0] addr;
   } host_req_s;

   typedef struct packed {
      logic     valid;
      logic     write;
      bp_addr_u addr;
   } bp_req_s;

   typedef struct packed {
      logic                        wr;
      logic                        rd;
      logic [csr_idx_width_lp-1:0] idx;
      logic [data_width_lp-1:0]    data;
   } csr_cmd_s;

endpackage

`default_nettype wire

// File: hdl/zynq_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module zynq_bridge_top
   import zynq_bridge_pkg::*;
(
   input  wire                       aclk_i,
   input  wire                       reset_i,
   input  wire host_req_s            host_req_i,
   input  wire bp_req_s              io_req_i,
   input  wire bp_req_s              dram_req_i,
   input  wire csr_cmd_s             csr_cmd_i,
   output bp_req_s                   bp_req_o,
   output bp_req_s                   host_io_o,
   output bp_req_s                   periph_io_o,
   output bp_req_s                   ps_dram_o,
   output logic                      dram_oob_o,
   output logic [data_width_lp-1:0]  csr_rdata_o,
   output logic                      csr_rvalid_o,
   output logic                      bp_reset_o
);

   logic [3:0][data_width_lp-1:0] profile;
   logic [addr_width_lp-1:0]      dram_base;
   logic                          ctrl_reset_n;
   logic                          bp_reset;

   // the core reset sits behind a register so a new program can be loaded
   // and launched without reprogramming the fabric
   assign bp_reset   = reset_i | ~ctrl_reset_n;
   assign bp_reset_o = bp_reset;

   host_addr_translator u_host_addr_translator (
      .aclk_i     (aclk_i),
      .reset_i    (reset_i),
      .host_req_i (host_req_i),
      .bp_req_o   (bp_req_o)
   );

   io_request_router u_io_request_router (
      .aclk_i      (aclk_i),
      .reset_i     (reset_i),
      .io_req_i    (io_req_i),
      .host_io_o   (host_io_o),
      .periph_io_o (periph_io_o)
   );

   dram_addr_translator u_dram_addr_translator (
      .aclk_i      (aclk_i),
      .reset_i     (reset_i),
      .dram_req_i  (dram_req_i),
      .dram_base_i (dram_base),
      .ps_dram_o   (ps_dram_o),
      .dram_oob_o  (dram_oob_o)
   );

   mem_profiler u_mem_profiler (
      .aclk_i     (aclk_i),
      .bp_reset_i (bp_reset),
      .dram_req_i (dram_req_i),
      .profile_o  (profile)
   );

   shell_csr_file u_shell_csr_file (
      .aclk_i         (aclk_i),
      .reset_i        (reset_i),
      .csr_cmd_i      (csr_cmd_i),
      .profile_i      (profile),
      .csr_rdata_o    (csr_rdata_o),
      .csr_rvalid_o   (csr_rvalid_o),
      .ctrl_reset_n_o (ctrl_reset_n),
      .dram_base_o    (dram_base)
   );

endmodule

`default_nettype wire

// File: sim/tb_zynq_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_zynq_bridge
   import zynq_bridge_pkg::*;
();

   localparam int period_lp          = 40;
   localparam int reset_cycles_lp    = 10;
   localparam int fixed_steps_lp     = 33;
   localparam int random_steps_lp    = 8;
   localparam int cycles_per_step_lp = 2;
   // twice the expected run length leaves room for the reset check
   localparam int timeout_ns_lp = 2 * period_lp * (reset_cycles_lp + 4 +
      (fixed_steps_lp + random_steps_lp) * cycles_per_step_lp);

   typedef enum logic [2:0] {
      op_csr_wr,
      op_csr_rd,
      op_host,
      op_io,
      op_dram
   } op_e;

   // flag is the expected bp_reset for writes, host channel for io, overrun for dram
   typedef struct packed {
      op_e         op;
      logic [2:0]  idx;
      logic [31:0] arg;
      logic [31:0] expect_word;
      logic        flag;
   } step_s;

   logic        clk;
   logic        reset;
   host_req_s   host_req;
   bp_req_s     io_req;
   bp_req_s     dram_req;
   csr_cmd_s    csr_cmd;
   bp_req_s     bp_req;
   bp_req_s     host_io;
   bp_req_s     periph_io;
   bp_req_s     ps_dram;
   logic        dram_oob;
   logic [31:0] csr_rdata;
   logic        csr_rvalid;
   logic        bp_reset;

   step_s       steps[$];
   int          mismatches;
   int          tests_run;
   int          tests_failed;
   logic [31:0] lcg_state;

   zynq_bridge_top u_zynq_bridge_top (
      .aclk_i       (clk),
      .reset_i      (reset),
      .host_req_i   (host_req),
      .io_req_i     (io_req),
      .dram_req_i   (dram_req),
      .csr_cmd_i    (csr_cmd),
      .bp_req_o     (bp_req),
      .host_io_o    (host_io),
      .periph_io_o  (periph_io),
      .ps_dram_o    (ps_dram),
      .dram_oob_o   (dram_oob),
      .csr_rdata_o  (csr_rdata),
      .csr_rvalid_o (csr_rvalid),
      .bp_reset_o   (bp_reset)
   );

   always #(period_lp / 2) clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // GP window below 512 MB is DRAM, the rest is BlackParrot local space
   function automatic logic [31:0] host_window_map(input logic [31:0] addr);
      if (addr < 32'h2000_0000) begin
         return addr + 32'h8000_0000;
      end else begin
         return addr - 32'h2000_0000;
      end
   endfunction

   function automatic step_s make_step(input op_e op, input logic [2:0] idx,
                                       input logic [31:0] arg,
                                       input logic [31:0] expect_word,
                                       input logic flag);
      step_s s;
      s.op          = op;
      s.idx         = idx;
      s.arg         = arg;
      s.expect_word = expect_word;
      s.flag        = flag;
      return s;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("Fail %s: got %h, expected %h", name, got, expected);
         mismatches++;
      end
   endtask

   task automatic build_table();
      logic [31:0] addr;
      // register file and core reset control
      steps.push_back(make_step(op_csr_wr, 3'd2, 32'h1000_0000, 32'h0, 1'b1));
      steps.push_back(make_step(op_csr_wr, 3'd1, 32'h0000_0001, 32'h0, 1'b1));
      steps.push_back(make_step(op_csr_rd, 3'd0, 32'h0, 32'h0000_0000, 1'b0));
      steps.push_back(make_step(op_csr_wr, 3'd0, 32'h0000_0001, 32'h0, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd0, 32'h0, 32'h0000_0001, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd1, 32'h0, 32'h0000_0001, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd2, 32'h0, 32'h1000_0000, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd3, 32'h0, 32'h0000_0000, 1'b0));
      steps.push_back(make_step(op_csr_wr, 3'd3, 32'hdead_beef, 32'h0, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd3, 32'h0, 32'h0000_0000, 1'b0));
      // host window on both sides of the split
      steps.push_back(make_step(op_host, 3'd0, 32'h0000_1000, 32'h8000_1000, 1'b0));
      steps.push_back(make_step(op_host, 3'd0, 32'h1fff_fffc, 32'h9fff_fffc, 1'b0));
      steps.push_back(make_step(op_host, 3'd0, 32'h2000_0000, 32'h0000_0000, 1'b0));
      steps.push_back(make_step(op_host, 3'd0, 32'h2ff0_0040, 32'h0ff0_0040, 1'b0));
      // device field sits in bits 23 to 20
      steps.push_back(make_step(op_io, 3'd0, 32'h0000_0100, 32'h0, 1'b1));
      steps.push_back(make_step(op_io, 3'd0, 32'h0010_0008, 32'h0, 1'b1));
      steps.push_back(make_step(op_io, 3'd0, 32'h0020_0000, 32'h0, 1'b0));
      steps.push_back(make_step(op_io, 3'd0, 32'h0030_0010, 32'h0, 1'b0));
      steps.push_back(make_step(op_io, 3'd0, 32'h0110_0000, 32'h0, 1'b1));
      // base is 0x1000_0000, profile bits 0, 1, 31, 32, 127 and 66
      steps.push_back(make_step(op_dram, 3'd0, 32'h8000_0000, 32'h1000_0000, 1'b0));
      steps.push_back(make_step(op_dram, 3'd0, 32'h8080_0040, 32'h1080_0040, 1'b0));
      steps.push_back(make_step(op_dram, 3'd0, 32'h8ff0_0000, 32'h1ff0_0000, 1'b0));
      steps.push_back(make_step(op_dram, 3'd0, 32'h9000_0000, 32'h2000_0000, 1'b1));
      steps.push_back(make_step(op_dram, 3'd0, 32'hbf80_0000, 32'h4f80_0000, 1'b1));
      steps.push_back(make_step(op_dram, 3'd0, 32'ha100_0000, 32'h3100_0000, 1'b1));
      steps.push_back(make_step(op_csr_rd, 3'd4, 32'h0, 32'h8000_0003, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd5, 32'h0, 32'h0000_0001, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd6, 32'h0, 32'h0000_0004, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd7, 32'h0, 32'h8000_0000, 1'b0));
      // pulsing the core reset empties the profile
      steps.push_back(make_step(op_csr_wr, 3'd0, 32'h0000_0000, 32'h0, 1'b1));
      steps.push_back(make_step(op_csr_wr, 3'd0, 32'h0000_0001, 32'h0, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd4, 32'h0, 32'h0000_0000, 1'b0));
      steps.push_back(make_step(op_csr_rd, 3'd7, 32'h0, 32'h0000_0000, 1'b0));
      for (int i = 0; i < random_steps_lp; i++) begin
         lcg_state = lcg_next(lcg_state);
         // stay below the end of the mapped local space
         addr = {2'b00, lcg_state[31:2]} % 32'h3000_0000;
         steps.push_back(make_step(op_host, 3'd0, addr, host_window_map(addr), 1'b0));
      end
   endtask

   task automatic drive_idle();
      host_req <= '0;
      io_req   <= '0;
      dram_req <= '0;
      csr_cmd  <= '0;
   endtask

   task automatic check_outputs(input step_s s);
      check_value("bp_req_o.valid", 32'(bp_req.valid), 32'(s.op == op_host));
      check_value("host_io_o.valid", 32'(host_io.valid), 32'(s.op == op_io && s.flag));
      check_value("periph_io_o.valid", 32'(periph_io.valid), 32'(s.op == op_io && !s.flag));
      check_value("ps_dram_o.valid", 32'(ps_dram.valid), 32'(s.op == op_dram));
      check_value("dram_oob_o", 32'(dram_oob), 32'(s.op == op_dram && s.flag));
      check_value("csr_rvalid_o", 32'(csr_rvalid), 32'(s.op == op_csr_rd));
      case (s.op)
         op_csr_wr: check_value("bp_reset_o", 32'(bp_reset), 32'(s.flag));
         op_csr_rd: check_value("csr_rdata_o", csr_rdata, s.expect_word);
         op_host: begin
            check_value("bp_req_o.addr", bp_req.addr, s.expect_word);
            check_value("bp_req_o.write", 32'(bp_req.write), 32'(^s.arg));
         end
         op_io: begin
            if (s.flag) begin
               check_value("host_io_o.addr", host_io.addr, s.arg);
               check_value("host_io_o.write", 32'(host_io.write), 32'(^s.arg));
            end else begin
               check_value("periph_io_o.addr", periph_io.addr, s.arg);
               check_value("periph_io_o.write", 32'(periph_io.write), 32'(^s.arg));
            end
         end
         default: begin
            check_value("ps_dram_o.addr", ps_dram.addr, s.expect_word);
            check_value("ps_dram_o.write", 32'(ps_dram.write), 32'(^s.arg));
         end
      endcase
   endtask

   // one strobe cycle, then idle, outputs sampled mid cycle after the register stage
   // the write bit follows the parity of the address so both values travel through
   task automatic apply_step(input step_s s);
      @(posedge clk);
      case (s.op)
         op_csr_wr: begin
            csr_cmd.wr   <= 1'b1;
            csr_cmd.idx  <= s.idx;
            csr_cmd.data <= s.arg;
         end
         op_csr_rd: begin
            csr_cmd.rd  <= 1'b1;
            csr_cmd.idx <= s.idx;
         end
         op_host: begin
            host_req.valid <= 1'b1;
            host_req.write <= ^s.arg;
            host_req.addr  <= s.arg[29:0];
         end
         op_io: begin
            io_req.valid <= 1'b1;
            io_req.write <= ^s.arg;
            io_req.addr  <= s.arg;
         end
         default: begin
            dram_req.valid <= 1'b1;
            dram_req.write <= ^s.arg;
            dram_req.addr  <= s.arg;
         end
      endcase
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_outputs(s);
   endtask

   initial begin
      #(timeout_ns_lp);
      $display("timeout after %0d ns, the test sequence did not finish", timeout_ns_lp);
      $display("Something failed");
      $finish;
   end

   initial begin
      int errors_before;
      clk          = 1'b0;
      reset        = 1'b1;
      host_req     = '0;
      io_req       = '0;
      dram_req     = '0;
      csr_cmd      = '0;
      mismatches   = 0;
      tests_run    = 0;
      tests_failed = 0;
      lcg_state    = 32'd13929;
      build_table();

      repeat (reset_cycles_lp) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      errors_before = mismatches;
      check_value("bp_reset_o", 32'(bp_reset), 32'h1);
      check_outputs(make_step(op_csr_wr, 3'd0, 32'h0, 32'h0, 1'b1));
      tests_run++;
      if (mismatches != errors_before) begin
         tests_failed++;
      end
      $display("test reset state: %s", (mismatches == errors_before) ? "ok" : "FAILED");

      for (int i = 0; i < steps.size(); i++) begin
         errors_before = mismatches;
         apply_step(steps[i]);
         tests_run++;
         if (mismatches != errors_before) begin
            tests_failed++;
         end
         $display("test %0d %s idx %0d arg %h: %s", i, steps[i].op.name(), steps[i].idx,
                  steps[i].arg, (mismatches == errors_before) ? "ok" : "FAILED");
      end

      $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
               tests_run, tests_run - tests_failed, tests_failed, mismatches);
      if (mismatches == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
hdl/zynq_bridge_pkg.sv
hdl/host_addr_translator.sv
hdl/io_request_router.sv
hdl/dram_addr_translator.sv
hdl/mem_profiler.sv
hdl/shell_csr_file.sv
hdl/zynq_bridge_top.sv
sim/tb_zynq_bridge.sv
